// ==== source/ring_defs.svh ====
`ifndef RING_DEFS_SVH
`define RING_DEFS_SVH

// Byte base addresses of the two node windows.
`define RING_JOY_BASE 32'h0000_1000
`define RING_RAW_BASE 32'h0000_1100

// Each window holds 2**RING_WIN_BITS words, picked by address bits 4:2.
`define RING_WIN_BITS 3

`define ADC_CHANNELS 8
`define ADC_FRAME_CYCLES 40
`define ADC_SCAN_CYCLES (`ADC_CHANNELS * `ADC_FRAME_CYCLES)

// Resistor-ladder joystick input.
`define JOY_CHANNEL 3

`endif

// ==== source/ring_pkg.sv ====
`include "ring_defs.svh"

package ring_pkg;

  typedef struct packed {
    logic        req;
    logic        ack;
    logic        write;
    logic [31:0] addr;
    logic [31:0] data;
  } ring_pkt_t;

  typedef struct packed {
    logic        write;
    logic [31:0] addr;
    logic [31:0] data;
  } host_req_t;

  typedef logic [11:0] adc_sample_t;
  typedef adc_sample_t [`ADC_CHANNELS-1:0] adc_bank_t;

  typedef struct packed {
    logic up;
    logic right;
    logic select;
    logic down;
    logic left;
  } joy_flags_t;

endpackage

// ==== source/adc_serial_ctrl.sv ====
`timescale 1ns/1ns
`include "ring_defs.svh"

module adc_serial_ctrl import ring_pkg::*; (
  input  logic      clk,
  input  logic      i_rst_n,
  output logic      o_adc_convst,
  output logic      o_adc_sck,
  output logic      o_adc_sdi,
  input  logic      i_adc_sdo,
  output adc_bank_t o_bank
);

  localparam int FRAME = `ADC_FRAME_CYCLES;
  localparam int CW    = $clog2(FRAME);
  localparam int CHW   = $clog2(`ADC_CHANNELS);

  localparam logic [CW-1:0] LAST      = CW'(FRAME - 1);
  localparam logic [CW-1:0] CONV_LEN  = CW'(2);
  localparam logic [CW-1:0] SCK_FIRST = CW'(14);
  localparam logic [CW-1:0] SCK_LAST  = CW'(14 + 24 - 1);

  logic [CW-1:0]  cnt;
  logic [CW-1:0]  cnt_nxt;
  logic [CW-1:0]  sck_ofs;
  logic [3:0]     bit_idx;
  logic           in_sck;
  logic           convst_nxt;
  logic           sck_nxt;
  logic           sdi_nxt;
  logic [CHW-1:0] cfg_ch;
  logic [CHW-1:0] prev_ch;
  logic           primed;
  logic [5:0]     cfg_word;
  logic [11:0]    sdi_frame;
  adc_sample_t    shift;

  // Single-ended, unipolar, no sleep. The LTC2308 address order is O/S, S1, S0.
  assign cfg_word  = {1'b1, cfg_ch[0], cfg_ch[2], cfg_ch[1], 1'b1, 1'b0};
  assign sdi_frame = {cfg_word, 6'b0};

  // Pin values are decoded from the next count so that they line up with cnt.
  always_comb begin
    cnt_nxt    = (cnt == LAST) ? '0 : cnt + 1'b1;
    in_sck     = (cnt_nxt >= SCK_FIRST) && (cnt_nxt <= SCK_LAST);
    sck_ofs    = cnt_nxt - SCK_FIRST;
    bit_idx    = sck_ofs[4:1];
    convst_nxt = cnt_nxt < CONV_LEN;
    sck_nxt    = in_sck && sck_ofs[0];
    sdi_nxt    = in_sck ? sdi_frame[4'd11 - bit_idx] : 1'b0;
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      cnt          <= '0;
      cfg_ch       <= '0;
      prev_ch      <= '0;
      primed       <= 1'b0;
      o_adc_convst <= 1'b0;
      o_adc_sck    <= 1'b0;
      o_adc_sdi    <= 1'b0;
    end else begin
      cnt          <= cnt_nxt;
      o_adc_convst <= convst_nxt;
      o_adc_sck    <= sck_nxt;
      o_adc_sdi    <= sdi_nxt;
      if (cnt == LAST) begin
        cfg_ch  <= cfg_ch + 1'b1;
        prev_ch <= cfg_ch;
        primed  <= 1'b1;
      end
    end
  end

  // SDO changes on the falling SCK edge, so it is taken while SCK is high.
  always_ff @(posedge clk) begin
    if (o_adc_sck) begin
      shift <= {shift[10:0], i_adc_sdo};
    end
  end

  // The converter answers one frame late, so the data belongs to the
  // channel that was configured in the previous frame.
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_bank <= '0;
    end else if (cnt == LAST && primed) begin
      o_bank[prev_ch] <= shift;
    end
  end

endmodule

// ==== source/joystick_node.sv ====
`timescale 1ns/1ns
`include "ring_defs.svh"

module joystick_node import ring_pkg::*; (
  input  logic      clk,
  input  logic      i_rst_n,
  input  adc_bank_t i_bank,
  input  ring_pkt_t i_ring,
  output ring_pkt_t o_ring
);

  localparam int          WLO  = `RING_WIN_BITS + 2;
  localparam logic [31:0] BASE = `RING_JOY_BASE;

  logic [2:0]               joy_code;
  joy_flags_t               flags;
  logic [`RING_WIN_BITS-1:0] word;
  logic                     hit;
  logic [31:0]              rd_data;
  ring_pkt_t                nxt;

  // The ladder puts each direction in its own band of the top three bits.
  assign joy_code = i_bank[`JOY_CHANNEL][11:9];

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      flags <= '0;
    end else begin
      flags.up     <= joy_code == 3'b101;
      flags.right  <= joy_code == 3'b011;
      flags.select <= joy_code == 3'b010;
      flags.down   <= joy_code == 3'b001;
      flags.left   <= joy_code == 3'b000;
    end
  end

  assign word = i_ring.addr[WLO-1:2];
  assign hit  = i_ring.req && (i_ring.addr[31:WLO] == BASE[31:WLO]);

  always_comb begin
    rd_data = '0;
    case (word)
      3'd0:    rd_data[0] = flags.up;
      3'd1:    rd_data[0] = flags.right;
      3'd2:    rd_data[0] = flags.select;
      3'd3:    rd_data[0] = flags.down;
      3'd4:    rd_data[0] = flags.left;
      default: rd_data = '0;
    endcase
  end

  always_comb begin
    nxt = i_ring;
    if (hit) begin
      nxt.req  = 1'b0;
      nxt.ack  = 1'b1;
      nxt.data = i_ring.write ? 32'h0 : rd_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_ring <= '0;
    end else begin
      o_ring <= nxt;
    end
  end

endmodule

// ==== source/adc_raw_node.sv ====
`timescale 1ns/1ns
`include "ring_defs.svh"

module adc_raw_node import ring_pkg::*; (
  input  logic      clk,
  input  logic      i_rst_n,
  input  adc_bank_t i_bank,
  input  ring_pkt_t i_ring,
  output ring_pkt_t o_ring
);

  localparam int          WLO  = `RING_WIN_BITS + 2;
  localparam logic [31:0] BASE = `RING_RAW_BASE;

  logic [`RING_WIN_BITS-1:0] word;
  logic                     hit;
  logic [31:0]              rd_data;
  ring_pkt_t                nxt;

  assign word    = i_ring.addr[WLO-1:2];
  assign hit     = i_ring.req && (i_ring.addr[31:WLO] == BASE[31:WLO]);
  assign rd_data = 32'(i_bank[word]);

  // Writes are claimed so the master sees an ack, but nothing is stored.
  always_comb begin
    nxt = i_ring;
    if (hit) begin
      nxt.req  = 1'b0;
      nxt.ack  = 1'b1;
      nxt.data = i_ring.write ? 32'h0 : rd_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_ring <= '0;
    end else begin
      o_ring <= nxt;
    end
  end

endmodule

// ==== source/ring_master.sv ====
`timescale 1ns/1ns

module ring_master import ring_pkg::*; (
  input  logic        clk,
  input  logic        i_rst_n,
  input  logic        i_host_req,
  input  host_req_t   i_host_cmd,
  output logic        o_host_ack,
  output logic        o_host_err,
  output logic [31:0] o_host_rdata,
  output ring_pkt_t   o_ring,
  input  ring_pkt_t   i_ring
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SENT,
    ST_ACKED
  } state_t;

  state_t    state;
  logic      req_q;
  logic      inject;
  logic      ret_valid;
  ring_pkt_t pkt;

  assign inject    = (state == ST_IDLE) && req_q;
  assign ret_valid = (state == ST_SENT) && (i_ring.req || i_ring.ack);

  always_comb begin
    pkt       = '0;
    pkt.req   = 1'b1;
    pkt.write = i_host_cmd.write;
    pkt.addr  = i_host_cmd.addr;
    pkt.data  = i_host_cmd.data;
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      state      <= ST_IDLE;
      req_q      <= 1'b0;
      o_host_ack <= 1'b0;
      o_host_err <= 1'b0;
      o_ring     <= '0;
    end else begin
      req_q  <= i_host_req;
      o_ring <= inject ? pkt : '0;
      case (state)
        ST_IDLE: begin
          if (req_q) begin
            state <= ST_SENT;
          end
        end
        ST_SENT: begin
          // A word that still carries req went round without being claimed.
          if (ret_valid) begin
            o_host_ack <= 1'b1;
            o_host_err <= i_ring.req;
            state      <= ST_ACKED;
          end
        end
        default: begin
          if (!req_q) begin
            o_host_ack <= 1'b0;
            o_host_err <= 1'b0;
            state      <= ST_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ret_valid) begin
      o_host_rdata <= i_ring.ack ? i_ring.data : 32'h0;
    end
  end

endmodule

// ==== source/joy_ring_top.sv ====
`timescale 1ns/1ns

module joy_ring_top import ring_pkg::*; (
  input  logic        clk,
  input  logic        i_rst_n,
  output logic        o_adc_convst,
  output logic        o_adc_sck,
  output logic        o_adc_sdi,
  input  logic        i_adc_sdo,
  input  logic        i_host_req,
  input  host_req_t   i_host_cmd,
  output logic        o_host_ack,
  output logic        o_host_err,
  output logic [31:0] o_host_rdata
);

  adc_bank_t bank;
  ring_pkt_t ring_m2j;
  ring_pkt_t ring_j2r;
  ring_pkt_t ring_r2m;

  adc_serial_ctrl u_adc (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .o_adc_convst (o_adc_convst),
    .o_adc_sck    (o_adc_sck),
    .o_adc_sdi    (o_adc_sdi),
    .i_adc_sdo    (i_adc_sdo),
    .o_bank       (bank)
  );

  ring_master u_master (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_host_req   (i_host_req),
    .i_host_cmd   (i_host_cmd),
    .o_host_ack   (o_host_ack),
    .o_host_err   (o_host_err),
    .o_host_rdata (o_host_rdata),
    .o_ring       (ring_m2j),
    .i_ring       (ring_r2m)
  );

  // Ring order is master, joystick, raw, and back to the master.
  joystick_node u_joy (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_bank  (bank),
    .i_ring  (ring_m2j),
    .o_ring  (ring_j2r)
  );

  adc_raw_node u_raw (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_bank  (bank),
    .i_ring  (ring_j2r),
    .o_ring  (ring_r2m)
  );

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock #(
  parameter int RESET_CYCLES = 4
) (
  output logic clk,
  output logic o_rst_n
);

  initial begin
    clk     = 1'b0;
    o_rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 o_rst_n = 1'b1;
  end

  always #5 clk = ~clk;

endmodule

// ==== test/adc_spi_model.sv ====
`timescale 1ns/1ns
`include "ring_defs.svh"

module adc_spi_model import ring_pkg::*; (
  input  logic      i_convst,
  input  logic      i_sck,
  input  logic      i_sdi,
  output logic      o_sdo,
  input  adc_bank_t i_values
);

  logic [11:0] sdi_shift = '0;
  logic [11:0] sdo_shift = '0;
  logic [5:0]  cfg;
  logic [2:0]  conv_ch;

  // Twelve SCK periods per frame, so after a frame the config word sits in the top six bits.
  assign cfg     = sdi_shift[11:6];

  // Single-ended channel address, S1 S0 O/S from high to low.
  assign conv_ch = {cfg[3], cfg[2], cfg[4]};
  assign o_sdo   = sdo_shift[11];

  always @(posedge i_sck) begin
    sdi_shift <= {sdi_shift[10:0], i_sdi};
  end

  // A conversion starts on the rising CONVST edge with the config of the
  // frame before. Its result leaves MSB first, one bit per falling SCK edge.
  always @(posedge i_convst or negedge i_sck) begin
    if (i_convst) begin
      sdo_shift <= i_values[conv_ch];
    end else begin
      sdo_shift <= {sdo_shift[10:0], 1'b0};
    end
  end

endmodule

// ==== test/joy_ring_properties.sv ====
`timescale 1ns/1ns

module joy_ring_properties (
  input logic clk,
  input logic i_rst_n,
  input logic i_host_req,
  input logic i_host_ack,
  input logic i_host_err,
  input logic i_adc_sck,
  input logic i_adc_convst
);

  int unsigned fail_count = 0;

  // A new ack is sampled one edge after it is set, when the host may already have dropped req.
  ack_rise_with_req: assert property (@(posedge clk) disable iff (!i_rst_n)
    $rose(i_host_ack) |-> $past(i_host_req))
    else begin
      fail_count++;
      $error("o_host_ack rose while i_host_req was low");
    end

  // The master registers the request, so ack drops two edges after req.
  ack_fall_after_req: assert property (@(posedge clk) disable iff (!i_rst_n)
    $fell(i_host_ack) |-> $past(!i_host_req))
    else begin
      fail_count++;
      $error("o_host_ack fell before i_host_req was seen low");
    end

  err_only_with_ack: assert property (@(posedge clk) disable iff (!i_rst_n)
    !(i_host_err && !i_host_ack))
    else begin
      fail_count++;
      $error("o_host_err was high while o_host_ack was low");
    end

  sck_quiet_in_convst: assert property (@(posedge clk) disable iff (!i_rst_n)
    !(i_adc_convst && i_adc_sck))
    else begin
      fail_count++;
      $error("o_adc_sck was high while o_adc_convst was high");
    end

  low_after_reset: assert property (@(posedge clk)
    $rose(i_rst_n) |-> !i_host_ack && !i_host_err && !i_adc_convst)
    else begin
      fail_count++;
      $error("ack, err or CONVST was high in the first cycle after reset");
    end

endmodule

// ==== test/joy_ring_tb.sv ====
`timescale 1ns/1ns
`include "ring_defs.svh"

module joy_ring_tb import ring_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 40 * `ADC_SCAN_CYCLES;
  localparam int ACK_WAIT       = 32;

  logic        clk;
  logic        rst_n;
  logic        adc_convst;
  logic        adc_sck;
  logic        adc_sdi;
  logic        adc_sdo;
  logic        host_req;
  host_req_t   host_cmd;
  logic        host_ack;
  logic        host_err;
  logic [31:0] host_rdata;
  adc_bank_t   adc_values;
  int          cycles = 0;

  tb_clock u_clock (
    .clk     (clk),
    .o_rst_n (rst_n)
  );

  adc_spi_model u_adc_model (
    .i_convst (adc_convst),
    .i_sck    (adc_sck),
    .i_sdi    (adc_sdi),
    .o_sdo    (adc_sdo),
    .i_values (adc_values)
  );

  joy_ring_top dut (
    .clk          (clk),
    .i_rst_n      (rst_n),
    .o_adc_convst (adc_convst),
    .o_adc_sck    (adc_sck),
    .o_adc_sdi    (adc_sdi),
    .i_adc_sdo    (adc_sdo),
    .i_host_req   (host_req),
    .i_host_cmd   (host_cmd),
    .o_host_ack   (host_ack),
    .o_host_err   (host_err),
    .o_host_rdata (host_rdata)
  );

  bind joy_ring_top joy_ring_properties u_props (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_host_req   (i_host_req),
    .i_host_ack   (o_host_ack),
    .i_host_err   (o_host_err),
    .i_adc_sck    (o_adc_sck),
    .i_adc_convst (o_adc_convst)
  );

  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1, "run stopped at %0t ns", $time);
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      abort_run();
    end else if (dut.u_props.fail_count != 0) begin
      $display("a bound assertion failed before %0t ns", $time);
      abort_run();
    end
  end

  task automatic check_value(input string name, input logic [31:0] addr,
                             input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp) else begin
      $display("mismatch at %0t ns: %s expected %h got %h (address %h)",
               $time, name, exp, got, addr);
      abort_run();
    end
  endtask

  // One full four-phase handshake, starting and ending 1 ns after an edge.
  task automatic host_xfer(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata, output logic err);
    int n;
    host_cmd.write = wr;
    host_cmd.addr  = addr;
    host_cmd.data  = wdata;
    host_req       = 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      #1;
      n++;
    end while (!host_ack && n < ACK_WAIT);
    if (!host_ack) begin
      $display("no ack within %0d cycles for address %h", ACK_WAIT, addr);
      abort_run();
    end
    rdata    = host_rdata;
    err      = host_err;
    host_req = 1'b0;
    n = 0;
    do begin
      @(posedge clk);
      #1;
      n++;
    end while (host_ack && n < ACK_WAIT);
    if (host_ack) begin
      $display("ack stayed high after the request dropped, address %h", addr);
      abort_run();
    end
  endtask

  task automatic check_read(input logic [31:0] addr, input logic [31:0] exp);
    logic [31:0] rd;
    logic        err;
    host_xfer(1'b0, addr, 32'h0, rd, err);
    check_value("o_host_err", addr, 32'd0, {31'd0, err});
    check_value("o_host_rdata", addr, exp, rd);
  endtask

  task automatic check_write(input logic [31:0] addr, input logic [31:0] wdata);
    logic [31:0] rd;
    logic        err;
    host_xfer(1'b1, addr, wdata, rd, err);
    check_value("o_host_err", addr, 32'd0, {31'd0, err});
    check_value("o_host_rdata", addr, 32'd0, rd);
  endtask

  task automatic check_unmapped(input logic [31:0] addr);
    logic [31:0] rd;
    logic        err;
    host_xfer(1'b0, addr, 32'h0, rd, err);
    check_value("o_host_err", addr, 32'd1, {31'd0, err});
    check_value("o_host_rdata", addr, 32'd0, rd);
  endtask

  // Every channel is converted at least once more within two scans.
  task automatic settle_adc();
    repeat (3 * `ADC_SCAN_CYCLES) @(posedge clk);
    #1;
  endtask

  // Direction words 0 to 4 are up, right, select, down and left.
  function automatic logic [31:0] joy_expected(input logic [2:0] code, input int word);
    int hit_word;
    case (code)
      3'b101:  hit_word = 0;
      3'b011:  hit_word = 1;
      3'b010:  hit_word = 2;
      3'b001:  hit_word = 3;
      3'b000:  hit_word = 4;
      default: hit_word = -1;
    endcase
    return (word == hit_word) ? 32'd1 : 32'd0;
  endfunction

  initial begin
    logic [2:0]  code;
    logic [31:0] wdata;
    host_req   = 1'b0;
    host_cmd   = '0;
    adc_values = '0;
    void'($urandom(32'h6c85501b));
    wait (rst_n === 1'b1);
    @(posedge clk);
    #1;

    for (int set = 0; set < 2; set++) begin
      for (int ch = 0; ch < `ADC_CHANNELS; ch++) begin
        adc_values[ch] = 12'($urandom);
      end
      settle_adc();
      for (int w = 0; w < `ADC_CHANNELS; w++) begin
        check_read(`RING_RAW_BASE + 32'(4 * w), {20'h0, adc_values[w]});
      end
    end

    wdata = $urandom;
    check_write(`RING_JOY_BASE + 32'd8, wdata);
    check_read(`RING_JOY_BASE + 32'd8, joy_expected(adc_values[`JOY_CHANNEL][11:9], 2));
    wdata = $urandom;
    check_write(`RING_RAW_BASE + 32'd20, wdata);
    check_read(`RING_RAW_BASE + 32'd20, {20'h0, adc_values[5]});

    check_unmapped(32'h0000_2000);
    check_unmapped(`RING_JOY_BASE + 32'd32);
    check_unmapped(`RING_RAW_BASE + 32'd32);

    for (int c = 0; c < 8; c++) begin
      code = 3'(c);
      adc_values[`JOY_CHANNEL] = {code, 9'($urandom)};
      settle_adc();
      for (int w = 0; w < 8; w++) begin
        check_read(`RING_JOY_BASE + 32'(4 * w), joy_expected(code, w));
      end
    end

    if (dut.u_props.fail_count != 0) begin
      $display("a bound assertion failed during the run");
      abort_run();
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

// ==== project.f ====
+incdir+source
source/ring_pkg.sv
source/adc_serial_ctrl.sv
source/joystick_node.sv
source/adc_raw_node.sv
source/ring_master.sv
source/joy_ring_top.sv
test/tb_clock.sv
test/adc_spi_model.sv
test/joy_ring_properties.sv
test/joy_ring_tb.sv

// ==== Makefile ====
TOP := joy_ring_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+100

clean:
	rm -rf obj_dir
